// File: compile.f
+incdir+testbench
source/mvu_pkg.sv
source/stage_if.sv
source/operand_ram.sv
source/job_ctrl.sv
source/operand_agu.sv
source/operand_fetch.sv
source/vvp_stage.sv
source/shacc_stage.sv
source/scale_quant_stage.sv
source/mvu_top.sv
testbench/tb_mvu_top.sv

// File: Bender.yml
package:
  name: mvu_lane

sources:
  - files:
      - source/mvu_pkg.sv
      - source/stage_if.sv
      - source/operand_ram.sv
      - source/job_ctrl.sv
      - source/operand_agu.sv
      - source/operand_fetch.sv
      - source/vvp_stage.sv
      - source/shacc_stage.sv
      - source/scale_quant_stage.sv
      - source/mvu_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mvu_top.sv

// File: testbench/tb_mvu_model.svh
`ifndef TB_MVU_MODEL_SVH
`define TB_MVU_MODEL_SVH

localparam int DEPTH = 2**mvu_pkg::ADDR_W;
localparam int EW    = mvu_pkg::ELEM_W;

mvu_pkg::vec_word_t w_mirror [DEPTH];   // Copy of weight memory
mvu_pkg::vec_word_t d_mirror [DEPTH];   // Copy of data memory
int value_errs = 0;
int flag_errs  = 0;

// Element taken as two's complement only when its operand is signed
function automatic int lane_value(input logic [EW-1:0] e, input logic sgn);
    if (sgn && e[EW-1]) begin
        return int'(e) - (1 << EW);
    end
    return int'(e);
endfunction

function automatic mvu_pkg::addr_t step_addr(input mvu_pkg::addr_t base,
                                             input mvu_pkg::addr_t stride,
                                             input mvu_pkg::addr_t len, input int k);
    int pos;
    pos = k % (int'(len) + 1);                  // Length held as count minus one
    return mvu_pkg::addr_t'((int'(base) + pos * int'(stride)) % DEPTH);
endfunction

function automatic mvu_pkg::result_t expected_result(input mvu_pkg::job_cfg_t j);
    longint             total;
    longint             scaled;
    mvu_pkg::vec_word_t w;
    mvu_pkg::vec_word_t d;
    total = 0;
    for (int k = 0; k < int'(j.countdown); k++) begin
        w = w_mirror[step_addr(j.wbaseaddr, j.wstride, j.wlength, k)];
        d = d_mirror[step_addr(j.ibaseaddr, j.istride, j.ilength, k)];
        for (int l = 0; l < mvu_pkg::LANES; l++) begin
            total += lane_value(w[l*EW +: EW], j.w_signed) * lane_value(d[l*EW +: EW], j.d_signed);
        end
    end
    total  = (total <<< (64 - mvu_pkg::ACC_W)) >>> (64 - mvu_pkg::ACC_W);  // Acc wraps
    scaled = total * longint'($signed(j.scaler_b));
    return mvu_pkg::result_t'(scaled >>> (int'(j.quant_msbidx) - (mvu_pkg::OUT_W - 1)));
endfunction

task automatic check_result(input mvu_pkg::result_t got, input mvu_pkg::result_t exp,
                            input int id);
    if (got !== exp) begin
        value_errs++;
        $display("ERROR at %0d ns: job %0d result %h, expected %h", $time, id, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string name, input int cyc_n);
    if (got !== exp) begin
        flag_errs++;
        if (exp) begin
            $display("%s missing at cycle %0d", name, cyc_n);
        end else begin
            $display("%s high at cycle %0d with nothing due", name, cyc_n);
        end
    end
endtask

`endif

// File: testbench/tb_mvu_top.sv
module tb_mvu_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED          = 32'h115c_57c6;
    localparam int RESET_CYC     = 16;
    localparam int IDLE_CYC      = 20;
    localparam int MAX_CNT       = 40;
    localparam int N_JOBS        = 32;     // Accepted and ignored starts
    localparam int N_REFRESH     = 4;
    localparam int REFRESH_WORDS = 16;
    localparam int LIMIT = RESET_CYC + IDLE_CYC + (2**mvu_pkg::ADDR_W + 1)
                         + N_REFRESH * (REFRESH_WORDS + 1) + N_JOBS * (MAX_CNT + 8);

    logic               clk = 1'b0;
    logic               rst_n;
    logic               start;
    mvu_pkg::cnt_t      countdown;
    mvu_pkg::addr_t     wbaseaddr;
    mvu_pkg::addr_t     wstride;
    mvu_pkg::addr_t     wlength;
    mvu_pkg::addr_t     ibaseaddr;
    mvu_pkg::addr_t     istride;
    mvu_pkg::addr_t     ilength;
    logic               d_signed;
    logic               w_signed;
    mvu_pkg::scale_t    scaler_b;
    mvu_pkg::msbidx_t   quant_msbidx;
    logic               wrw_en;
    mvu_pkg::addr_t     wrw_addr;
    mvu_pkg::vec_word_t wrw_word;
    logic               wrc_en;
    mvu_pkg::addr_t     wrc_addr;
    mvu_pkg::vec_word_t wrc_word;
    logic               done;
    logic               irq;
    logic               result_valid;
    mvu_pkg::result_t   result;

    int               cyc      = 0;        // Rising edges so far
    logic             checking = 1'b0;
    logic             irq_exp  = 1'b0;
    int               job_id   = 0;
    int               accept_q  [$];       // Edge that accepts each start
    int               done_q    [$];
    int               res_cyc_q [$];
    mvu_pkg::result_t res_val_q [$];
    int               res_id_q  [$];

    `include "tb_mvu_model.svh"

    mvu_top dut0 (
        .clk(clk), .rst_n(rst_n), .start(start), .countdown(countdown),
        .wbaseaddr(wbaseaddr), .wstride(wstride), .wlength(wlength),
        .ibaseaddr(ibaseaddr), .istride(istride), .ilength(ilength),
        .d_signed(d_signed), .w_signed(w_signed), .scaler_b(scaler_b),
        .quant_msbidx(quant_msbidx),
        .wrw_en(wrw_en), .wrw_addr(wrw_addr), .wrw_word(wrw_word),
        .wrc_en(wrc_en), .wrc_addr(wrc_addr), .wrc_word(wrc_word),
        .done(done), .irq(irq), .result_valid(result_valid), .result(result)
    );

    always #20 clk = ~clk;                  // 40 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("Timeout after %0d cycles with jobs still pending", LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic mvu_pkg::job_cfg_t random_job(input bit wrap_addr, input bit rand_scale);
        mvu_pkg::job_cfg_t j;
        j.countdown    = mvu_pkg::cnt_t'($urandom_range(MAX_CNT, 1));
        j.wbaseaddr    = mvu_pkg::addr_t'($urandom);
        j.ibaseaddr    = mvu_pkg::addr_t'($urandom);
        j.wstride      = wrap_addr ? mvu_pkg::addr_t'($urandom) : mvu_pkg::addr_t'(1);
        j.istride      = wrap_addr ? mvu_pkg::addr_t'($urandom) : mvu_pkg::addr_t'(1);
        j.wlength      = wrap_addr ? mvu_pkg::addr_t'($urandom_range(7, 0))
                                   : mvu_pkg::addr_t'(DEPTH - 1);  // Short wrap or none
        j.ilength      = wrap_addr ? mvu_pkg::addr_t'($urandom_range(7, 0))
                                   : mvu_pkg::addr_t'(DEPTH - 1);
        j.d_signed     = 1'($urandom);
        j.w_signed     = 1'($urandom);
        j.scaler_b     = rand_scale ? mvu_pkg::scale_t'($urandom) : mvu_pkg::scale_t'(1);
        j.quant_msbidx = rand_scale
            ? mvu_pkg::msbidx_t'($urandom_range(mvu_pkg::PROD_W - 1, mvu_pkg::OUT_W - 1))
            : mvu_pkg::msbidx_t'(mvu_pkg::OUT_W - 1);
        return j;
    endfunction

    task automatic write_words(input int n, input bit sequential);
        mvu_pkg::addr_t     wa;
        mvu_pkg::addr_t     da;
        mvu_pkg::vec_word_t ww;
        mvu_pkg::vec_word_t dw;
        for (int i = 0; i < n; i++) begin
            wa = sequential ? mvu_pkg::addr_t'(i) : mvu_pkg::addr_t'($urandom);
            da = sequential ? mvu_pkg::addr_t'(i) : mvu_pkg::addr_t'($urandom);
            ww = mvu_pkg::vec_word_t'($urandom);
            dw = mvu_pkg::vec_word_t'($urandom);
            @(posedge clk);
            wrw_en   <= 1'b1;
            wrw_addr <= wa;
            wrw_word <= ww;
            wrc_en   <= 1'b1;
            wrc_addr <= da;
            wrc_word <= dw;
            w_mirror[wa] = ww;
            d_mirror[da] = dw;
        end
        @(posedge clk);
        wrw_en <= 1'b0;
        wrc_en <= 1'b0;
    endtask

    task automatic start_job(input mvu_pkg::job_cfg_t j, input bit accepted);
        int s;
        @(posedge clk);
        s = cyc + 2;                        // cyc still holds the previous edge count
        start        <= 1'b1;
        countdown    <= j.countdown;
        wbaseaddr    <= j.wbaseaddr;
        wstride      <= j.wstride;
        wlength      <= j.wlength;
        ibaseaddr    <= j.ibaseaddr;
        istride      <= j.istride;
        ilength      <= j.ilength;
        d_signed     <= j.d_signed;
        w_signed     <= j.w_signed;
        scaler_b     <= j.scaler_b;
        quant_msbidx <= j.quant_msbidx;
        @(posedge clk);
        start <= 1'b0;
        if (accepted) begin
            accept_q.push_back(s);
            done_q.push_back(s + int'(j.countdown));
            res_cyc_q.push_back(s + int'(j.countdown) + 3);
            res_val_q.push_back(expected_result(j));
            res_id_q.push_back(job_id);
            job_id++;
        end
    endtask

    task automatic wait_results(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (result_valid === 1'b1) begin
                seen++;
            end
        end
    endtask

    task automatic run_job(input mvu_pkg::job_cfg_t j);
        start_job(j, 1'b1);
        wait_results(1);
    endtask

    // Strobe schedule and result check, sampled away from the driving edge
    always @(negedge clk) begin : monitor
        logic exp_done;
        logic exp_rv;
        exp_done = 1'b0;
        exp_rv   = 1'b0;
        if (checking) begin
            if (accept_q.size() != 0 && accept_q[0] == cyc) begin
                irq_exp = 1'b0;             // Accepted start clears irq
                void'(accept_q.pop_front());
            end
            if (done_q.size() != 0 && done_q[0] == cyc) begin
                exp_done = 1'b1;
                irq_exp  = 1'b1;            // Sets with done
                void'(done_q.pop_front());
            end
            if (res_cyc_q.size() != 0 && res_cyc_q[0] == cyc) begin
                exp_rv = 1'b1;
                if (result_valid === 1'b1) begin
                    check_result(result, res_val_q[0], res_id_q[0]);
                end
                void'(res_cyc_q.pop_front());
                void'(res_val_q.pop_front());
                void'(res_id_q.pop_front());
            end
            check_flag(done, exp_done, "done", cyc);
            check_flag(irq, irq_exp, "irq", cyc);
            check_flag(result_valid, exp_rv, "result_valid", cyc);
        end
    end

    initial begin
        mvu_pkg::job_cfg_t j;
        mvu_pkg::job_cfg_t j2;
        void'($urandom(SEED));
        rst_n        = 1'b0;
        start        = 1'b0;
        countdown    = '0;
        wbaseaddr    = '0;
        wstride      = '0;
        wlength      = '0;
        ibaseaddr    = '0;
        istride      = '0;
        ilength      = '0;
        d_signed     = 1'b0;
        w_signed     = 1'b0;
        scaler_b     = '0;
        quant_msbidx = '0;
        wrw_en       = 1'b0;
        wrw_addr     = '0;
        wrw_word     = '0;
        wrc_en       = 1'b0;
        wrc_addr     = '0;
        wrc_word     = '0;
        repeat (RESET_CYC) @(posedge clk);
        rst_n    <= 1'b1;
        checking <= 1'b1;
        repeat (IDLE_CYC) @(posedge clk);   // Flags must stay low with no start
        write_words(DEPTH, 1'b1);
        for (int n = 0; n < 4; n++) begin   // Plain unsigned dot product
            j = random_job(1'b0, 1'b0);
            j.d_signed = 1'b0;
            j.w_signed = 1'b0;
            run_job(j);
        end
        write_words(REFRESH_WORDS, 1'b0);
        for (int c = 0; c < 8; c++) begin   // Each signedness pair twice
            j = random_job(1'b0, 1'b0);
            j.d_signed = c[1];
            j.w_signed = c[0];
            run_job(j);
        end
        write_words(REFRESH_WORDS, 1'b0);
        for (int n = 0; n < 6; n++) begin
            run_job(random_job(1'b1, 1'b0));
        end
        write_words(REFRESH_WORDS, 1'b0);
        for (int n = 0; n < 6; n++) begin
            run_job(random_job(1'b0, 1'b1));
        end
        write_words(REFRESH_WORDS, 1'b0);
        j = random_job(1'b1, 1'b1);
        j.countdown = mvu_pkg::cnt_t'($urandom_range(MAX_CNT, 4));
        start_job(j, 1'b1);
        j2 = random_job(1'b1, 1'b1);
        start_job(j2, 1'b0);                // Arrives while run is high
        wait_results(1);
        for (int n = 0; n < 3; n++) begin
            j  = random_job(1'b1, 1'b1);
            j2 = random_job(1'b1, 1'b1);
            start_job(j, 1'b1);
            repeat (int'(j.countdown)) @(posedge clk);
            start_job(j2, 1'b1);            // Sampled in cycle C+2 of the first
            wait_results(2);
        end
        repeat (4) @(negedge clk);          // Quiet tail catches late strobes
        if (res_cyc_q.size() != 0) begin
            flag_errs++;
            $display("%0d expected results never arrived", res_cyc_q.size());
        end
        $display("Run summary: %0d jobs, %0d value errors, %0d strobe errors",
                 job_id, value_errs, flag_errs);
        if (value_errs == 0 && flag_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: source/mvu_top.sv
module mvu_top #(
    parameter int LANES  = mvu_pkg::LANES,
    parameter int ELEM_W = mvu_pkg::ELEM_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  mvu_pkg::cnt_t       countdown,
    input  mvu_pkg::addr_t      wbaseaddr,
    input  mvu_pkg::addr_t      wstride,
    input  mvu_pkg::addr_t      wlength,
    input  mvu_pkg::addr_t      ibaseaddr,
    input  mvu_pkg::addr_t      istride,
    input  mvu_pkg::addr_t      ilength,
    input  logic                d_signed,
    input  logic                w_signed,
    input  mvu_pkg::scale_t     scaler_b,
    input  mvu_pkg::msbidx_t    quant_msbidx,
    input  logic                wrw_en,
    input  mvu_pkg::addr_t      wrw_addr,
    input  mvu_pkg::vec_word_t  wrw_word,
    input  logic                wrc_en,
    input  mvu_pkg::addr_t      wrc_addr,
    input  mvu_pkg::vec_word_t  wrc_word,
    output logic                done,
    output logic                irq,
    output logic                result_valid,
    output mvu_pkg::result_t    result
);

    mvu_pkg::job_cfg_t cfg;             // Latched job configuration
    logic              run;
    logic              sum_valid;
    mvu_pkg::acc_t     sum;

    stage_if #(.payload_t(mvu_pkg::addr_pair_t))    agu_link ();
    stage_if #(.payload_t(mvu_pkg::operand_pair_t)) op_link ();
    stage_if #(.payload_t(mvu_pkg::acc_t))          prod_link ();

    job_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .countdown    (countdown),
        .wbaseaddr    (wbaseaddr),
        .wstride      (wstride),
        .wlength      (wlength),
        .ibaseaddr    (ibaseaddr),
        .istride      (istride),
        .ilength      (ilength),
        .d_signed     (d_signed),
        .w_signed     (w_signed),
        .scaler_b     (scaler_b),
        .quant_msbidx (quant_msbidx),
        .cfg          (cfg),
        .run          (run),
        .done         (done),
        .irq          (irq)
    );

    operand_agu u_agu (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .run      (run),
        .agu_link (agu_link.src)
    );

    operand_fetch #(.DEPTH(2**mvu_pkg::ADDR_W)) u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .wrw_en   (wrw_en),
        .wrw_addr (wrw_addr),
        .wrw_word (wrw_word),
        .wrc_en   (wrc_en),
        .wrc_addr (wrc_addr),
        .wrc_word (wrc_word),
        .agu_link (agu_link.dst),
        .op_link  (op_link.src)
    );

    vvp_stage #(.LANES(LANES), .ELEM_W(ELEM_W)) u_vvp (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .op_link   (op_link.dst),
        .prod_link (prod_link.src)
    );

    shacc_stage u_shacc (
        .clk       (clk),
        .rst_n     (rst_n),
        .prod_link (prod_link.dst),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    scale_quant_stage u_quant (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .sum_valid    (sum_valid),
        .sum          (sum),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// File: source/scale_quant_stage.sv
module scale_quant_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  mvu_pkg::job_cfg_t   cfg,
    input  logic                sum_valid,
    input  mvu_pkg::acc_t       sum,
    output logic                result_valid,
    output mvu_pkg::result_t    result
);

    localparam int PROD_W = mvu_pkg::PROD_W;
    localparam int OUT_W  = mvu_pkg::OUT_W;

    mvu_pkg::scale_t         scaler_q;  // Scaler one cycle behind cfg
    mvu_pkg::msbidx_t        msbidx_q;
    logic signed [PROD_W-1:0] scaled;

    // A following job reloads cfg the cycle before this job's sum
    always_ff @(posedge clk) begin
        scaler_q <= cfg.scaler_b;
        msbidx_q <= cfg.quant_msbidx;
    end

    assign scaled = sum * scaler_q;     // Signed, full width

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= sum_valid;
        end
        if (sum_valid) begin
            result <= scaled[msbidx_q -: OUT_W];  // Window below MSB, wraps
        end
    end

    a_msbidx_range: assert property (@(posedge clk) disable iff (!rst_n)
        sum_valid |-> (msbidx_q >= OUT_W - 1) && (msbidx_q < PROD_W))
        else $error("scale_quant_stage MSB index out of range");

endmodule

// File: source/shacc_stage.sv
module shacc_stage (
    input  logic          clk,
    input  logic          rst_n,
    stage_if.dst          prod_link,
    output logic          sum_valid,
    output mvu_pkg::acc_t sum
);

    logic job_open;                     // Between first and last item

    always_ff @(posedge clk) begin
        if (prod_link.valid) begin
            if (prod_link.first) begin
                sum <= prod_link.payload;           // Load opens the job
            end else begin
                sum <= sum + prod_link.payload;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
            job_open  <= 1'b0;
        end else begin
            sum_valid <= prod_link.valid && prod_link.last;
            if (prod_link.valid) begin
                job_open <= !prod_link.last;        // Single-item jobs never open
            end
        end
    end

    a_item_in_open_job: assert property (@(posedge clk) disable iff (!rst_n)
        (prod_link.valid && !prod_link.first) |-> job_open)
        else $error("shacc_stage item without an open job");

endmodule

// File: source/vvp_stage.sv
module vvp_stage #(
    parameter int LANES  = 8,
    parameter int ELEM_W = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  mvu_pkg::job_cfg_t cfg,
    stage_if.dst              op_link,
    stage_if.src              prod_link
);

    logic signed [ELEM_W:0]     w_ext [LANES];  // Lane with sign or zero bit
    logic signed [ELEM_W:0]     d_ext [LANES];
    logic signed [2*ELEM_W+1:0] prod  [LANES];  // Lane product
    mvu_pkg::acc_t              lane_sum;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic [ELEM_W-1:0] w_el;
        logic [ELEM_W-1:0] d_el;

        assign w_el     = op_link.payload.wword[l*ELEM_W +: ELEM_W];
        assign d_el     = op_link.payload.dword[l*ELEM_W +: ELEM_W];
        assign w_ext[l] = {cfg.w_signed & w_el[ELEM_W-1], w_el};  // Extend per signedness
        assign d_ext[l] = {cfg.d_signed & d_el[ELEM_W-1], d_el};
        assign prod[l]  = w_ext[l] * d_ext[l];
    end

    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < LANES; l++) begin
            lane_sum = lane_sum + mvu_pkg::acc_t'(prod[l]);  // Sign extended add
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_link.valid <= 1'b0;
        end else begin
            prod_link.valid <= op_link.valid;
        end
        prod_link.first   <= op_link.first;
        prod_link.last    <= op_link.last;
        prod_link.payload <= lane_sum;  // Dot product of one pair
    end

endmodule

// File: source/operand_fetch.sv
module operand_fetch #(
    parameter int DEPTH = 512
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wrw_en,
    input  mvu_pkg::addr_t      wrw_addr,
    input  mvu_pkg::vec_word_t  wrw_word,
    input  logic                wrc_en,
    input  mvu_pkg::addr_t      wrc_addr,
    input  mvu_pkg::vec_word_t  wrc_word,
    stage_if.dst                agu_link,
    stage_if.src                op_link
);

    localparam int LAT = mvu_pkg::MEM_RD_LAT;

    mvu_pkg::vec_word_t w_rd;           // Weight read data
    mvu_pkg::vec_word_t d_rd;           // Data read data
    logic [2:0]         mark_q [LAT];   // valid, first, last per delay stage

    operand_ram #(.word_t(mvu_pkg::vec_word_t), .DEPTH(DEPTH)) w_ram (
        .clk     (clk),
        .wr_en   (wrw_en),
        .wr_addr (wrw_addr),
        .wr_word (wrw_word),
        .rd_addr (agu_link.payload.waddr),
        .rd_word (w_rd)
    );

    operand_ram #(.word_t(mvu_pkg::vec_word_t), .DEPTH(DEPTH)) d_ram (
        .clk     (clk),
        .wr_en   (wrc_en),
        .wr_addr (wrc_addr),
        .wr_word (wrc_word),
        .rd_addr (agu_link.payload.iaddr),
        .rd_word (d_rd)
    );

    // Markers follow the read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LAT; i++) begin
                mark_q[i] <= '0;
            end
        end else begin
            mark_q[0] <= {agu_link.valid, agu_link.first, agu_link.last};
            for (int i = 1; i < LAT; i++) begin
                mark_q[i] <= mark_q[i-1];
            end
        end
    end

    assign {op_link.valid, op_link.first, op_link.last} = mark_q[LAT-1];
    assign op_link.payload = '{wword: w_rd, dword: d_rd};

endmodule

// File: source/operand_agu.sv
module operand_agu (
    input  logic              clk,
    input  logic              rst_n,
    input  mvu_pkg::job_cfg_t cfg,
    input  logic              run,
    stage_if.src              agu_link
);

    mvu_pkg::cnt_t  step;               // Item index within the job
    mvu_pkg::addr_t base   [2];         // Index 0 weights, 1 data
    mvu_pkg::addr_t stride [2];
    mvu_pkg::addr_t len    [2];         // Wrap length minus one
    mvu_pkg::addr_t wrap   [2];         // Position inside wrap length
    mvu_pkg::addr_t ofs    [2];         // wrap times stride, mod depth

    assign base   = '{cfg.wbaseaddr, cfg.ibaseaddr};
    assign stride = '{cfg.wstride, cfg.istride};
    assign len    = '{cfg.wlength, cfg.ilength};

    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            step <= '0;                 // Idle keeps counters at job start
            for (int i = 0; i < 2; i++) begin
                wrap[i] <= '0;
                ofs[i]  <= '0;
            end
        end else begin
            step <= step + 1'b1;
            for (int i = 0; i < 2; i++) begin
                if (wrap[i] == len[i]) begin
                    wrap[i] <= '0;      // Back to base address
                    ofs[i]  <= '0;
                end else begin
                    wrap[i] <= wrap[i] + 1'b1;
                    ofs[i]  <= ofs[i] + stride[i];
                end
            end
        end
    end

    assign agu_link.valid   = run;      // One item per run cycle
    assign agu_link.first   = run && (step == '0);
    assign agu_link.last    = run && (step == cfg.countdown - 1'b1);
    assign agu_link.payload = '{waddr: base[0] + ofs[0], iaddr: base[1] + ofs[1]};

endmodule

// File: source/job_ctrl.sv
module job_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  mvu_pkg::cnt_t       countdown,
    input  mvu_pkg::addr_t      wbaseaddr,
    input  mvu_pkg::addr_t      wstride,
    input  mvu_pkg::addr_t      wlength,
    input  mvu_pkg::addr_t      ibaseaddr,
    input  mvu_pkg::addr_t      istride,
    input  mvu_pkg::addr_t      ilength,
    input  logic                d_signed,
    input  logic                w_signed,
    input  mvu_pkg::scale_t     scaler_b,
    input  mvu_pkg::msbidx_t    quant_msbidx,
    output mvu_pkg::job_cfg_t   cfg,
    output logic                run,
    output logic                done,
    output logic                irq
);

    mvu_pkg::cnt_t remaining;           // Steps left including current
    logic          accept;              // Start seen while idle
    logic          finish;              // Last run cycle

    assign accept = start && !run;
    assign finish = run && (remaining == mvu_pkg::cnt_t'(1));

    // Configuration buffer, held for the whole job
    always_ff @(posedge clk) begin
        if (accept) begin
            cfg <= '{countdown: countdown, wbaseaddr: wbaseaddr, wstride: wstride,
                     wlength: wlength, ibaseaddr: ibaseaddr, istride: istride,
                     ilength: ilength, d_signed: d_signed, w_signed: w_signed,
                     scaler_b: scaler_b, quant_msbidx: quant_msbidx};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run       <= 1'b0;
            done      <= 1'b0;
            irq       <= 1'b0;
            remaining <= '0;
        end else begin
            done <= finish;             // Single cycle after last step
            if (accept) begin
                run       <= 1'b1;
                remaining <= countdown;
                irq       <= 1'b0;      // New job clears pending irq
            end else if (run) begin
                remaining <= remaining - 1'b1;
                if (finish) begin
                    run <= 1'b0;
                    irq <= 1'b1;        // Held until next start
                end
            end
        end
    end

    a_countdown_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> countdown != '0)
        else $error("job_ctrl started with zero countdown");

endmodule

// File: source/operand_ram.sv
module operand_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 512
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  word_t                    wr_word,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output word_t                    rd_word
);

    word_t mem [DEPTH];                 // Vector storage

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;    // Host write
        end
        rd_word <= mem[rd_addr];        // Registered read, one cycle
    end

    a_wr_addr_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_addr))
        else $error("operand_ram write with unknown address");

endmodule

// File: source/stage_if.sv
interface stage_if #(
    parameter type payload_t = logic
);

    logic     valid;                    // One item this cycle
    logic     first;                    // Item opens a job
    logic     last;                     // Item closes a job
    payload_t payload;

    modport src (output valid, first, last, payload);
    modport dst (input valid, first, last, payload);

endinterface

// File: source/mvu_pkg.sv
package mvu_pkg;

    parameter int LANES      = 8;   // Elements per vector word
    parameter int ELEM_W     = 4;   // Bits per element
    parameter int ADDR_W     = 9;   // Both memories, 512 deep
    parameter int CNT_W      = 10;  // Job step countdown
    parameter int ACC_W      = 27;  // Accumulator width
    parameter int SCALE_W    = 16;  // Scaler operand, signed
    parameter int PROD_W     = 48;  // Scaled product
    parameter int MSBIDX_W   = 6;   // Quantizer window MSB index
    parameter int OUT_W      = 16;  // Quantized result
    parameter int MEM_RD_LAT = 1;   // Memory read latency

    typedef logic [LANES*ELEM_W-1:0]   vec_word_t;
    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [CNT_W-1:0]          cnt_t;
    typedef logic signed [SCALE_W-1:0] scale_t;
    typedef logic [MSBIDX_W-1:0]       msbidx_t;
    typedef logic signed [ACC_W-1:0]   acc_t;
    typedef logic [OUT_W-1:0]          result_t;

    typedef struct packed {
        addr_t waddr;                   // Weight memory read address
        addr_t iaddr;                   // Data memory read address
    } addr_pair_t;

    typedef struct packed {
        vec_word_t wword;               // Weight vector word
        vec_word_t dword;               // Data vector word
    } operand_pair_t;

    // Lengths are stored as actual length minus one
    typedef struct packed {
        cnt_t    countdown;             // Steps in the job
        addr_t   wbaseaddr;
        addr_t   wstride;
        addr_t   wlength;
        addr_t   ibaseaddr;
        addr_t   istride;
        addr_t   ilength;
        logic    d_signed;              // Data lanes signed
        logic    w_signed;              // Weight lanes signed
        scale_t  scaler_b;              // Multiplicative scaler
        msbidx_t quant_msbidx;          // Top bit of output window
    } job_cfg_t;

endpackage
